// ==== Makefile ====
# Verilator build and run for the conv layer testbench

VERILATOR ?= verilator
TOP       ?= conv_layer_tb
RTL_TOP   ?= conv_layer_top
FILELIST  ?= conv_layer_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== conv_layer_top.f ====
logic/conv_pkg.sv
logic/frame_ram.sv
logic/replay_buffer.sv
logic/weight_store.sv
logic/channel_accumulator.sv
logic/conv_layer_top.sv
testbench/conv_layer_tb.sv

// ==== logic/channel_accumulator.sv ====
`timescale 1ns/1ps

module channel_accumulator (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  rd_valid,
	input  logic [conv_pkg::PXL_WIDTH-1:0]        rd_pixel,
	input  logic [conv_pkg::IC_WIDTH-1:0]         rd_ic,
	input  logic [conv_pkg::OC_WIDTH-1:0]         rd_oc,
	input  logic [conv_pkg::POS_WIDTH-1:0]        rd_pos,
	input  logic signed [conv_pkg::WT_WIDTH-1:0]  wt_value,
	output logic                                  res_valid,
	output logic signed [conv_pkg::ACC_WIDTH-1:0] res_data,
	output logic [conv_pkg::OC_WIDTH-1:0]         res_oc,
	output logic [conv_pkg::POS_WIDTH-1:0]        res_pos
);
	import conv_pkg::*;

	// Pixel is unsigned, so widen with a zero sign bit
	logic signed [PXL_WIDTH:0] pxl_s;

	logic                        s1_valid;
	logic signed [ACC_WIDTH-1:0] s1_prod;
	logic [IC_WIDTH-1:0]         s1_ic;
	logic [OC_WIDTH-1:0]         s1_oc;
	logic [POS_WIDTH-1:0]        s1_pos;

	// One partial sum per pixel position
	logic signed [ACC_WIDTH-1:0] psum [IMAGE_SIZE];
	logic signed [ACC_WIDTH-1:0] sum_next;
	logic                        first_ic;
	logic                        last_ic;

	////////////////////////////////////////////////////////////////////////////
	// Stage 1, multiply

	assign pxl_s = $signed({1'b0, rd_pixel});

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= rd_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_valid) begin
			s1_prod <= ACC_WIDTH'(pxl_s) * ACC_WIDTH'(wt_value);
			s1_ic   <= rd_ic;
			s1_oc   <= rd_oc;
			s1_pos  <= rd_pos;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 2, accumulate over input channels

	assign first_ic = (s1_ic == '0);
	assign last_ic  = (s1_ic == IC_WIDTH'(IN_CH - 1));

	// First channel starts a fresh sum
	assign sum_next = first_ic ? s1_prod : psum[s1_pos] + s1_prod;

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			psum[s1_pos] <= sum_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= s1_valid && last_ic;
		end
	end

	// Completed sum leaves with its indices
	always_ff @(posedge clk) begin
		if (s1_valid && last_ic) begin
			res_data <= sum_next;
			res_oc   <= s1_oc;
			res_pos  <= s1_pos;
		end
	end

endmodule

// ==== logic/conv_layer_top.sv ====
`timescale 1ns/1ps

module conv_layer_top (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  wt_we,
	input  logic [conv_pkg::WT_ADDR_WIDTH-1:0]    wt_addr,
	input  logic signed [conv_pkg::WT_WIDTH-1:0]  wt_data,
	input  logic                                  pxl_valid,
	input  logic [conv_pkg::PXL_WIDTH-1:0]        pxl_data,
	output logic                                  res_valid,
	output logic signed [conv_pkg::ACC_WIDTH-1:0] res_data,
	output logic [conv_pkg::OC_WIDTH-1:0]         res_oc,
	output logic [conv_pkg::POS_WIDTH-1:0]        res_pos,
	output logic                                  busy,
	output logic                                  done
);
	import conv_pkg::*;

	// Replay bus
	logic                       rd_valid;
	logic [PXL_WIDTH-1:0]       rd_pixel;
	logic [IC_WIDTH-1:0]        rd_ic;
	logic [OC_WIDTH-1:0]        rd_oc;
	logic [POS_WIDTH-1:0]       rd_pos;
	logic signed [WT_WIDTH-1:0] wt_value;

	replay_buffer u_replay_buffer (
		.clk      (clk),
		.reset    (reset),
		.pxl_valid(pxl_valid),
		.pxl_data (pxl_data),
		.rd_valid (rd_valid),
		.rd_pixel (rd_pixel),
		.rd_ic    (rd_ic),
		.rd_oc    (rd_oc),
		.rd_pos   (rd_pos),
		.busy     (busy),
		.done     (done)
	);

	weight_store u_weight_store (
		.clk     (clk),
		.reset   (reset),
		.wt_we   (wt_we),
		.wt_addr (wt_addr),
		.wt_data (wt_data),
		.rd_oc   (rd_oc),
		.rd_ic   (rd_ic),
		.wt_value(wt_value)
	);

	channel_accumulator u_channel_accumulator (
		.clk      (clk),
		.reset    (reset),
		.rd_valid (rd_valid),
		.rd_pixel (rd_pixel),
		.rd_ic    (rd_ic),
		.rd_oc    (rd_oc),
		.rd_pos   (rd_pos),
		.wt_value (wt_value),
		.res_valid(res_valid),
		.res_data (res_data),
		.res_oc   (res_oc),
		.res_pos  (res_pos)
	);

endmodule

// ==== logic/conv_pkg.sv ====
package conv_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data widths

	// Unsigned pixel, signed weight
	localparam int PXL_WIDTH = 8;
	localparam int WT_WIDTH  = 8;
	// Partial sums and results
	localparam int ACC_WIDTH = 20;

	////////////////////////////////////////////////////////////////////////////
	// Layer geometry

	localparam int IMAGE_WIDTH = 4;
	localparam int IMAGE_SIZE  = IMAGE_WIDTH * IMAGE_WIDTH;
	localparam int IN_CH       = 2;
	localparam int OUT_CH      = 3;
	// One frame holds every input channel, channel-major
	localparam int FRAME_DEPTH = IN_CH * IMAGE_SIZE;

	// Index widths
	localparam int ADDR_WIDTH    = 5;
	localparam int POS_WIDTH     = 4;
	localparam int IC_WIDTH      = 1;
	localparam int OC_WIDTH      = 2;
	localparam int WT_ADDR_WIDTH = 3;
	localparam int WT_COUNT      = OUT_CH * IN_CH;

	////////////////////////////////////////////////////////////////////////////
	// Replay control

	// Idle cycles between two passes
	localparam int GAP_CYCLES = 4;
	localparam int GAP_WIDTH  = 2;

	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_play,
		st_gap
	} replay_state_t;

endpackage

// ==== logic/frame_ram.sv ====
`timescale 1ns/1ps

module frame_ram (
	input  logic                            clk,
	input  logic                            ram_en,
	input  logic                            ram_we,
	input  logic [conv_pkg::ADDR_WIDTH-1:0] ram_addr,
	input  logic [conv_pkg::PXL_WIDTH-1:0]  ram_wdata,
	output logic [conv_pkg::PXL_WIDTH-1:0]  ram_rdata
);
	import conv_pkg::*;

	// One full frame, all input channels
	logic [PXL_WIDTH-1:0] mem [FRAME_DEPTH];

	// Single port, read-first on a write
	always_ff @(posedge clk) begin
		if (ram_en) begin
			if (ram_we) begin
				mem[ram_addr] <= ram_wdata;
			end
			ram_rdata <= mem[ram_addr];
		end
	end

endmodule

// ==== logic/replay_buffer.sv ====
`timescale 1ns/1ps

module replay_buffer (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           pxl_valid,
	input  logic [conv_pkg::PXL_WIDTH-1:0] pxl_data,
	output logic                           rd_valid,
	output logic [conv_pkg::PXL_WIDTH-1:0] rd_pixel,
	output logic [conv_pkg::IC_WIDTH-1:0]  rd_ic,
	output logic [conv_pkg::OC_WIDTH-1:0]  rd_oc,
	output logic [conv_pkg::POS_WIDTH-1:0] rd_pos,
	output logic                           busy,
	output logic                           done
);
	import conv_pkg::*;

	replay_state_t state;

	logic [ADDR_WIDTH-1:0] addr;
	logic [OC_WIDTH-1:0]   pass;
	logic [GAP_WIDTH-1:0]  gap_cnt;

	logic                 wr_pend;
	logic [PXL_WIDTH-1:0] pxl_data_q;

	logic last_addr;
	logic last_pass;
	logic load_full;
	logic accept;
	logic rd_issue;

	logic ram_en;
	logic ram_we;

	////////////////////////////////////////////////////////////////////////////
	// Input side

	assign last_addr = (addr == ADDR_WIDTH'(FRAME_DEPTH - 1));
	assign last_pass = (pass == OC_WIDTH'(OUT_CH - 1));

	// Final write of the frame happens this cycle
	assign load_full = wr_pend && last_addr;

	// Strobes only count while a frame is being loaded
	assign accept = pxl_valid &&
		((state == st_idle) || ((state == st_load) && !load_full));

	// Pixel sits one cycle in a register before the RAM write
	always_ff @(posedge clk) begin
		if (accept) begin
			pxl_data_q <= pxl_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_pend <= 1'b0;
		end else begin
			wr_pend <= accept;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Load and replay sequencing

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= st_idle;
			addr    <= '0;
			pass    <= '0;
			gap_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					addr <= '0;
					pass <= '0;
					if (accept) begin
						state <= st_load;
					end
				end
				st_load: begin
					if (wr_pend) begin
						if (last_addr) begin
							addr  <= '0;
							state <= st_play;
						end else begin
							addr <= addr + 1'b1;
						end
					end
				end
				st_play: begin
					// One read per cycle, whole frame per pass
					if (last_addr) begin
						addr <= '0;
						if (last_pass) begin
							state <= st_idle;
						end else begin
							state   <= st_gap;
							gap_cnt <= '0;
						end
					end else begin
						addr <= addr + 1'b1;
					end
				end
				st_gap: begin
					if (gap_cnt == GAP_WIDTH'(GAP_CYCLES - 1)) begin
						state <= st_play;
						pass  <= pass + 1'b1;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	assign rd_issue = (state == st_play);
	assign busy     = (state != st_idle);

	// Write only happens while loading
	assign ram_we = wr_pend;
	assign ram_en = ram_we || rd_issue;

	frame_ram u_frame_ram (
		.clk      (clk),
		.ram_en   (ram_en),
		.ram_we   (ram_we),
		.ram_addr (addr),
		.ram_wdata(pxl_data_q),
		.ram_rdata(rd_pixel)
	);

	////////////////////////////////////////////////////////////////////////////
	// Output side, aligned with the RAM read latency

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid <= 1'b0;
			done     <= 1'b0;
		end else begin
			rd_valid <= rd_issue;
			done     <= rd_issue && last_addr && last_pass;
		end
	end

	// Channel is the upper address bit, position the rest
	always_ff @(posedge clk) begin
		if (rd_issue) begin
			rd_ic  <= addr[ADDR_WIDTH-1 -: IC_WIDTH];
			rd_pos <= addr[POS_WIDTH-1:0];
			rd_oc  <= pass;
		end
	end

endmodule

// ==== logic/weight_store.sv ====
`timescale 1ns/1ps

module weight_store (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  wt_we,
	input  logic [conv_pkg::WT_ADDR_WIDTH-1:0]    wt_addr,
	input  logic signed [conv_pkg::WT_WIDTH-1:0]  wt_data,
	input  logic [conv_pkg::OC_WIDTH-1:0]         rd_oc,
	input  logic [conv_pkg::IC_WIDTH-1:0]         rd_ic,
	output logic signed [conv_pkg::WT_WIDTH-1:0]  wt_value
);
	import conv_pkg::*;

	// Indexed by output channel times IN_CH plus input channel
	logic signed [WT_WIDTH-1:0] wt_mem [WT_COUNT];
	logic [WT_ADDR_WIDTH-1:0]   rd_addr;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < WT_COUNT; i++) begin
				wt_mem[i] <= '0;
			end
		end else if (wt_we && (wt_addr < WT_ADDR_WIDTH'(WT_COUNT))) begin
			wt_mem[wt_addr] <= wt_data;
		end
	end

	// Lookup for the pixel currently on the replay bus
	assign rd_addr  = WT_ADDR_WIDTH'(rd_oc * IN_CH + rd_ic);
	assign wt_value = wt_mem[rd_addr];

endmodule

// ==== testbench/conv_layer_input.txt ====
# w <weight address> <signed weight> | p <pixel> <idle cycles after it> | f ends a frame
# Several records may share a line, pixels are channel-major
w 0 3
w 1 -2
w 2 -128
w 3 127
w 4 1
w 5 -1
# Frame 1, back-to-back strobes
p 12 0  p 255 0  p 0 0  p 7 0
p 100 0  p 33 0  p 250 0  p 1 0
p 64 0  p 128 0  p 19 0  p 201 0
p 90 0  p 45 0  p 3 0  p 177 0
p 5 0  p 240 0  p 66 0  p 128 0
p 255 0  p 0 0  p 81 0  p 14 0
p 150 0  p 9 0  p 222 0  p 37 0
p 60 0  p 199 0  p 2 0  p 255 0
f
# Frame 2, new weights on two addresses, irregular strobe spacing
w 0 -7
w 3 -45
p 200 1  p 13 0  p 77 3  p 255 2
p 0 0  p 142 1  p 8 0  p 99 2
p 31 3  p 160 0  p 245 1  p 4 0
p 118 2  p 55 0  p 190 3  p 27 1
p 250 0  p 6 2  p 133 0  p 71 1
p 12 3  p 208 0  p 44 2  p 255 0
p 97 1  p 180 0  p 3 3  p 66 0
p 149 2  p 21 0  p 230 1  p 88 2
f

// ==== testbench/conv_layer_tb.sv ====
`timescale 1ns/1ps

module conv_layer_tb;
	import conv_pkg::*;

	localparam int NUM_FRAMES    = 2;
	localparam int FRAME_RESULTS = OUT_CH * IMAGE_SIZE;
	localparam int MAX_CYCLES    =
		2 * (NUM_FRAMES * (OUT_CH * (FRAME_DEPTH + GAP_CYCLES) + FRAME_DEPTH * 4)) + 200;
	// Idle cycles between result bursts and latency from last pixel to first result
	localparam int BURST_IDLE    = GAP_CYCLES + IMAGE_SIZE * (IN_CH - 1);
	localparam int FIRST_LATENCY = IMAGE_SIZE * (IN_CH - 1) + 4;
	localparam int JUNK_STROBES  = 6;

	logic                         clk;
	logic                         reset;
	logic                         wt_we;
	logic [WT_ADDR_WIDTH-1:0]     wt_addr;
	logic signed [WT_WIDTH-1:0]   wt_data;
	logic                         pxl_valid;
	logic [PXL_WIDTH-1:0]         pxl_data;
	logic                         res_valid;
	logic signed [ACC_WIDTH-1:0]  res_data;
	logic [OC_WIDTH-1:0]          res_oc;
	logic [POS_WIDTH-1:0]         res_pos;
	logic                         busy;
	logic                         done;

	int errors = 0;
	int cycle = 0;
	int res_count = 0;
	int done_count = 0;
	int frames = 0;
	int pix_count = 0;
	int strobe_cycle = 0;
	int last_res_cycle = 0;
	int weights [WT_COUNT];
	int pixels [FRAME_DEPTH];
	int expected [FRAME_RESULTS];

	int               fd;
	int               rc;
	int               arg_a;
	int               arg_b;
	logic [7:0]       kind;
	logic [8*128-1:0] line_buf;

	conv_layer_top uut (
		.clk      (clk),
		.reset    (reset),
		.wt_we    (wt_we),
		.wt_addr  (wt_addr),
		.wt_data  (wt_data),
		.pxl_valid(pxl_valid),
		.pxl_data (pxl_data),
		.res_valid(res_valid),
		.res_data (res_data),
		.res_oc   (res_oc),
		.res_pos  (res_pos),
		.busy     (busy),
		.done     (done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Cycle count and run limit
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Result monitor on the falling edge

	always @(negedge clk) begin
		if (!reset) begin
			if (done) begin
				done_count++;
			end
			if (res_valid) begin
				check_result();
			end
		end
	end

	task check_result;
		int k;
		int exp_oc;
		int exp_pos;
		k = res_count % FRAME_RESULTS;
		exp_oc = k / IMAGE_SIZE;
		exp_pos = k % IMAGE_SIZE;
		if (int'(res_oc) != exp_oc) begin
			$display("[FAIL] %0t res_oc: got %0d, expected %0d", $time, res_oc, exp_oc);
			errors++;
		end
		if (int'(res_pos) != exp_pos) begin
			$display("[FAIL] %0t res_pos: got %0d, expected %0d", $time, res_pos, exp_pos);
			errors++;
		end
		if (int'(res_data) != expected[k]) begin
			$display("[FAIL] %0t res_data: got %0d, expected %0d", $time, res_data,
				expected[k]);
			errors++;
		end
		// Burst timing
		if (k == 0) begin
			if (cycle - strobe_cycle != FIRST_LATENCY) begin
				$display("first result came %0d cycles after the last pixel, not %0d",
					cycle - strobe_cycle, FIRST_LATENCY);
				errors++;
			end
		end else if (k % IMAGE_SIZE == 0) begin
			if (cycle - last_res_cycle - 1 != BURST_IDLE) begin
				$display("gap before output channel %0d was %0d idle cycles, not %0d",
					exp_oc, cycle - last_res_cycle - 1, BURST_IDLE);
				errors++;
			end
		end else if (cycle != last_res_cycle + 1) begin
			$display("result burst broke before position %0d of output channel %0d",
				exp_pos, exp_oc);
			errors++;
		end
		last_res_cycle = cycle;
		res_count++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and reference model

	// Each result is the weighted sum over input channels
	task compute_expected;
		int sum;
		for (int oc = 0; oc < OUT_CH; oc++) begin
			for (int pos = 0; pos < IMAGE_SIZE; pos++) begin
				sum = 0;
				for (int ic = 0; ic < IN_CH; ic++) begin
					sum += weights[oc * IN_CH + ic] * pixels[ic * IMAGE_SIZE + pos];
				end
				expected[oc * IMAGE_SIZE + pos] = sum;
			end
		end
	endtask

	task write_weight(input int addr, input int value);
		@(negedge clk);
		pxl_valid = 1'b0;
		wt_we = 1'b1;
		wt_addr = WT_ADDR_WIDTH'(addr);
		wt_data = WT_WIDTH'(value);
		weights[addr] = value;
		@(negedge clk);
		wt_we = 1'b0;
	endtask

	task send_pixel(input int value, input int idle);
		@(negedge clk);
		pxl_valid = 1'b1;
		pxl_data = PXL_WIDTH'(value);
		strobe_cycle = cycle + 1;
		pixels[pix_count] = value;
		pix_count++;
		if (pix_count == FRAME_DEPTH) begin
			compute_expected();
		end
		repeat (idle) begin
			@(negedge clk);
			pxl_valid = 1'b0;
		end
	endtask

	// Random strobes that the DUT must ignore while busy
	task send_ignored_strobes;
		int gap;
		repeat (JUNK_STROBES) begin
			@(negedge clk);
			if (busy !== 1'b1) begin
				$display("[FAIL] %0t busy: got %b, expected 1", $time, busy);
				errors++;
			end
			pxl_valid = 1'b1;
			pxl_data = PXL_WIDTH'($urandom);
			gap = $urandom % 3;
			repeat (gap) begin
				@(negedge clk);
				pxl_valid = 1'b0;
			end
		end
		@(negedge clk);
		pxl_valid = 1'b0;
	endtask

	task finish_frame;
		if (pix_count != FRAME_DEPTH) begin
			$display("frame %0d held %0d pixels instead of %0d", frames + 1, pix_count,
				FRAME_DEPTH);
			errors++;
		end
		pix_count = 0;
		send_ignored_strobes();
		while (res_count < (frames + 1) * FRAME_RESULTS) begin
			@(negedge clk);
		end
		// Room for any stray result or pulse
		repeat (BURST_IDLE + 4) @(negedge clk);
		frames++;
		if (res_count != frames * FRAME_RESULTS) begin
			$display("frame %0d ended with %0d results in total, expected %0d", frames,
				res_count, frames * FRAME_RESULTS);
			errors++;
		end
		if (done_count != frames) begin
			$display("done pulsed %0d times after %0d frames", done_count, frames);
			errors++;
		end
		if (busy !== 1'b0) begin
			$display("[FAIL] %0t busy: got %b, expected 0", $time, busy);
			errors++;
		end
	endtask

	task check_idle_outputs;
		repeat (3) begin
			@(negedge clk);
			if (res_valid !== 1'b0) begin
				$display("[FAIL] %0t res_valid: got %b, expected 0", $time, res_valid);
				errors++;
			end
			if (busy !== 1'b0) begin
				$display("[FAIL] %0t busy: got %b, expected 0", $time, busy);
				errors++;
			end
			if (done !== 1'b0) begin
				$display("[FAIL] %0t done: got %b, expected 0", $time, done);
				errors++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		reset = 1'b1;
		wt_we = 1'b0;
		wt_addr = '0;
		wt_data = '0;
		pxl_valid = 1'b0;
		pxl_data = '0;
		void'($urandom(78));
		for (int i = 0; i < WT_COUNT; i++) begin
			weights[i] = 0;
		end
		repeat (4) @(negedge clk);
		reset = 1'b0;
		check_idle_outputs();

		fd = $fopen("testbench/conv_layer_input.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/conv_layer_input.txt");
			errors++;
		end else begin
			while ($fscanf(fd, " %c", kind) == 1) begin
				case (kind)
					"w", "p": begin
						rc = $fscanf(fd, "%d %d", arg_a, arg_b);
						if (rc != 2) begin
							$display("malformed %c record in the input file", kind);
							errors++;
						end else if (kind == "w") begin
							write_weight(arg_a, arg_b);
						end else begin
							send_pixel(arg_a, arg_b);
						end
					end
					"f": finish_frame();
					"#": rc = $fgets(line_buf, fd);
					default: begin
						$display("unknown record type %c in the input file", kind);
						errors++;
					end
				endcase
			end
			$fclose(fd);
		end
		if (frames != NUM_FRAMES) begin
			$display("input file gave %0d frames instead of %0d", frames, NUM_FRAMES);
			errors++;
		end

		$display("errors: %0d, results: %0d, done pulses: %0d", errors, res_count,
			done_count);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
